// ==== source/clk_delay_pkg.sv ====
package clk_delay_pkg;

    // fixed-point formats, one time unit per lsb
    localparam int dt_width = 16;
    localparam int time_width = 32;

    // delay code as seen on the control port
    localparam int code_width = 9;

    // largest timestep that can be granted in one emulator cycle
    localparam logic [dt_width-1:0] dt_max = dt_width'((2 ** (dt_width - 1)) - 1);

    // jitter source, x^16 + x^14 + x^13 + x^11
    localparam int lfsr_width = 16;
    localparam logic [lfsr_width-1:0] lfsr_poly = 16'hB400;

    // fallback state, an all-zero lfsr never leaves zero
    localparam logic [lfsr_width-1:0] lfsr_seed_default = 16'h0001;

    // one step of the right-shifting galois lfsr
    function automatic logic [lfsr_width-1:0] lfsr_step(
        input logic [lfsr_width-1:0] state
    );
        logic [lfsr_width-1:0] shifted;
        shifted = state >> 1;
        if (state[0]) begin
            shifted = shifted ^ lfsr_poly;
        end
        return shifted;
    endfunction

    // seed from the low lfsr bits of a wider seed word
    function automatic logic [lfsr_width-1:0] lfsr_seed(
        input logic [31:0] seed
    );
        logic [lfsr_width-1:0] low;
        low = seed[lfsr_width-1:0];
        return (low == '0) ? lfsr_seed_default : low;
    endfunction

endpackage

// ==== source/timestep_ctrl.sv ====
`timescale 1ns/1ps

module timestep_ctrl (
    input  logic                                  emu_clk,
    input  logic                                  arst_n,
    input  logic [clk_delay_pkg::dt_width-1:0]    dt_req,
    input  logic [clk_delay_pkg::dt_width-1:0]    dt_req_dly,
    output logic [clk_delay_pkg::dt_width-1:0]    emu_dt,
    output logic [clk_delay_pkg::time_width-1:0]  emu_time,
    output logic [clk_delay_pkg::time_width-1:0]  next_time
);

    localparam int tw = clk_delay_pkg::time_width;

    logic [clk_delay_pkg::dt_width-1:0] dt_min_req;

    // grant the smallest request, then cap it
    always_comb begin
        dt_min_req = (dt_req < dt_req_dly) ? dt_req : dt_req_dly;
        if (dt_min_req < clk_delay_pkg::dt_max) begin
            emu_dt = dt_min_req;
        end else begin
            emu_dt = clk_delay_pkg::dt_max;
        end
    end

    // time at the end of the step being taken now
    assign next_time = emu_time + tw'(emu_dt);

    always_ff @(posedge emu_clk or negedge arst_n) begin
        if (!arst_n) begin
            emu_time <= '0;
        end else begin
            emu_time <= next_time;
        end
    end

    // with both requesters asking for a real step, a real step is granted
    step_granted: assert property (
        @(posedge emu_clk) disable iff (!arst_n)
        (dt_req != '0 && dt_req_dly != '0) |-> (emu_dt != '0)
    );

endmodule

// ==== source/jitter_gen.sv ====
`timescale 1ns/1ps

module jitter_gen (
    input  logic                                emu_clk,
    input  logic                                arst_n,
    input  logic [31:0]                         jitter_seed,
    input  logic [clk_delay_pkg::dt_width-1:0]  jitter_mask,
    input  logic                                edge_seen,
    output logic [clk_delay_pkg::dt_width-1:0]  jitter
);

    localparam int dw = clk_delay_pkg::dt_width;
    localparam int lw = clk_delay_pkg::lfsr_width;

    logic [lw-1:0] lfsr_q;
    logic [lw-1:0] lfsr_cur;
    logic          seeded;

    // until the first clock after reset the seed itself is the state
    assign lfsr_cur = seeded ? lfsr_q : clk_delay_pkg::lfsr_seed(jitter_seed);

    // bounded offset for the edge seen in this cycle
    assign jitter = dw'(lfsr_cur) & jitter_mask;

    always_ff @(posedge emu_clk or negedge arst_n) begin
        if (!arst_n) begin
            seeded <= 1'b0;
            lfsr_q <= clk_delay_pkg::lfsr_seed_default;
        end else begin
            seeded <= 1'b1;
            // one step per input edge, so each edge gets a fresh value
            if (edge_seen) begin
                lfsr_q <= clk_delay_pkg::lfsr_step(lfsr_cur);
            end else begin
                lfsr_q <= lfsr_cur;
            end
        end
    end

endmodule

// ==== source/edge_queue.sv ====
`timescale 1ns/1ps

module edge_queue #(
    parameter int queue_depth = 8
) (
    input  logic                                  emu_clk,
    input  logic                                  arst_n,
    input  logic                                  push,
    input  logic [clk_delay_pkg::time_width-1:0]  push_time,
    input  logic                                  pop,
    output logic [clk_delay_pkg::time_width-1:0]  head_time,
    output logic [clk_delay_pkg::time_width-1:0]  tail_time,
    output logic                                  empty,
    output logic                                  full
);

    localparam int tw = clk_delay_pkg::time_width;
    localparam int ptr_width = (queue_depth > 1) ? $clog2(queue_depth) : 1;
    localparam int cnt_width = $clog2(queue_depth + 1);

    logic [tw-1:0]        mem [queue_depth];
    logic [ptr_width-1:0] rd_ptr;
    logic [ptr_width-1:0] wr_ptr;
    logic [ptr_width-1:0] rd_ptr_inc;
    logic [ptr_width-1:0] wr_ptr_inc;
    logic [cnt_width-1:0] count;

    // pointers wrap at the depth, which need not be a power of two
    assign rd_ptr_inc = (rd_ptr == ptr_width'(queue_depth - 1)) ? '0 : rd_ptr + 1'b1;
    assign wr_ptr_inc = (wr_ptr == ptr_width'(queue_depth - 1)) ? '0 : wr_ptr + 1'b1;

    assign empty = (count == '0);
    assign full  = (count == cnt_width'(queue_depth));

    always_ff @(posedge emu_clk or negedge arst_n) begin
        if (!arst_n) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr_inc;
            end
            if (pop) begin
                rd_ptr <= rd_ptr_inc;
            end
            count <= count + cnt_width'(push) - cnt_width'(pop);
        end
    end

    always_ff @(posedge emu_clk) begin
        if (push) begin
            mem[wr_ptr] <= push_time;
        end
    end

    // head and tail kept in registers so the scheduler sees no read path
    always_ff @(posedge emu_clk) begin
        if (push) begin
            tail_time <= push_time;
        end
        if (pop) begin
            if (count > cnt_width'(1)) begin
                head_time <= mem[rd_ptr_inc];
            end else if (push) begin
                head_time <= push_time;
            end
        end else if (empty && push) begin
            head_time <= push_time;
        end
    end

    // the scheduler drops edges instead of pushing into a full queue
    no_push_full: assert property (
        @(posedge emu_clk) disable iff (!arst_n)
        push |-> !full
    );

    no_pop_empty: assert property (
        @(posedge emu_clk) disable iff (!arst_n)
        pop |-> !empty
    );

    // deadlines leave in the order they came in
    push_rising: assert property (
        @(posedge emu_clk) disable iff (!arst_n)
        (push && !empty) |-> (push_time > tail_time)
    );

endmodule

// ==== source/edge_sched_fsm.sv ====
`timescale 1ns/1ps

module edge_sched_fsm #(
    parameter int delay_lsb = 4
) (
    input  logic                                  emu_clk,
    input  logic                                  arst_n,
    input  logic [clk_delay_pkg::code_width-1:0]  code,
    input  logic                                  clk_i_val,
    input  logic [clk_delay_pkg::time_width-1:0]  emu_time,
    input  logic [clk_delay_pkg::time_width-1:0]  next_time,
    input  logic [clk_delay_pkg::dt_width-1:0]    jitter,
    input  logic [clk_delay_pkg::time_width-1:0]  head_time,
    input  logic [clk_delay_pkg::time_width-1:0]  tail_time,
    input  logic                                  empty,
    input  logic                                  full,
    output logic                                  edge_seen,
    output logic [clk_delay_pkg::dt_width-1:0]    dt_req_dly,
    output logic                                  push,
    output logic [clk_delay_pkg::time_width-1:0]  push_time,
    output logic                                  pop,
    output logic                                  clk_o_val,
    output logic                                  overflow
);

    localparam int tw = clk_delay_pkg::time_width;
    localparam int dw = clk_delay_pkg::dt_width;

    typedef enum logic [1:0] {
        st_idle,
        st_pending,
        st_overflowed
    } state_t;

    state_t        state;
    state_t        state_next;
    logic          clk_i_q;
    logic [tw-1:0] cand_raw;
    logic [tw-1:0] cand_floor;
    logic [tw-1:0] cand_time;
    logic [tw-1:0] near_time;
    logic [tw-1:0] gap;
    logic          near_valid;
    logic          bypass;
    logic          drop;

    assign edge_seen = clk_i_val ^ clk_i_q;

    // nominal deadline, code steps of delay_lsb plus jitter
    assign cand_raw = emu_time + tw'(code) * tw'(delay_lsb) + tw'(jitter);

    // not in the past, and behind anything already queued
    always_comb begin
        cand_floor = emu_time + tw'(1);
        if (!empty && (tail_time + tw'(1)) > cand_floor) begin
            cand_floor = tail_time + tw'(1);
        end
        cand_time = (cand_raw < cand_floor) ? cand_floor : cand_raw;
    end

    // pop and bypass never coincide, a queued head always comes first
    assign pop       = !empty && (next_time == head_time);
    assign bypass    = edge_seen && (next_time == cand_time);
    assign push      = edge_seen && !bypass && !full;
    assign drop      = edge_seen && !bypass && full;
    assign push_time = cand_time;
    assign overflow  = (state == st_overflowed);

    // ask for a step that lands exactly on the nearest deadline
    always_comb begin
        near_valid = 1'b1;
        near_time  = emu_time;
        if (!empty && edge_seen) begin
            near_time = (head_time < cand_time) ? head_time : cand_time;
        end else if (!empty) begin
            near_time = head_time;
        end else if (edge_seen) begin
            near_time = cand_time;
        end else begin
            near_valid = 1'b0;
        end
        gap = near_time - emu_time;
        if (!near_valid || gap > tw'(clk_delay_pkg::dt_max)) begin
            dt_req_dly = clk_delay_pkg::dt_max;
        end else begin
            dt_req_dly = gap[dw-1:0];
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            st_idle: begin
                if (drop) begin
                    state_next = st_overflowed;
                end else if (push) begin
                    state_next = st_pending;
                end
            end
            st_pending: begin
                if (drop) begin
                    state_next = st_overflowed;
                end else if (empty && !push) begin
                    state_next = st_idle;
                end
            end
            // sticky until reset
            st_overflowed: state_next = st_overflowed;
            default: state_next = st_idle;
        endcase
    end

    always_ff @(posedge emu_clk or negedge arst_n) begin
        if (!arst_n) begin
            state     <= st_idle;
            clk_i_q   <= 1'b0;
            clk_o_val <= 1'b0;
        end else begin
            state   <= state_next;
            clk_i_q <= clk_i_val;
            if (pop || bypass) begin
                clk_o_val <= ~clk_o_val;
            end
        end
    end

    // the granted step may land on the head deadline but never beyond it
    head_not_passed: assert property (
        @(posedge emu_clk) disable iff (!arst_n)
        !empty |-> (next_time <= head_time)
    );

endmodule

// ==== source/clk_delay_top.sv ====
`timescale 1ns/1ps

module clk_delay_top #(
    parameter int delay_lsb   = 4,
    parameter int queue_depth = 8
) (
    input  logic                                  emu_clk,
    input  logic                                  arst_n,
    input  logic [clk_delay_pkg::code_width-1:0]  code,
    input  logic                                  clk_i_val,
    input  logic [clk_delay_pkg::dt_width-1:0]    dt_req,
    input  logic [31:0]                           jitter_seed,
    input  logic [clk_delay_pkg::dt_width-1:0]    jitter_mask,
    output logic                                  clk_o_val,
    output logic [clk_delay_pkg::dt_width-1:0]    emu_dt,
    output logic [clk_delay_pkg::time_width-1:0]  emu_time,
    output logic                                  overflow
);

    logic [clk_delay_pkg::dt_width-1:0]   dt_req_dly;
    logic [clk_delay_pkg::time_width-1:0] next_time;
    logic [clk_delay_pkg::dt_width-1:0]   jitter;
    logic                                 edge_seen;
    logic                                 push;
    logic                                 pop;
    logic [clk_delay_pkg::time_width-1:0] push_time;
    logic [clk_delay_pkg::time_width-1:0] head_time;
    logic [clk_delay_pkg::time_width-1:0] tail_time;
    logic                                 empty;
    logic                                 full;

    // step arbitration between the outside world and the delay line
    timestep_ctrl timestep_ctrl_i (
        .emu_clk    (emu_clk),
        .arst_n     (arst_n),
        .dt_req     (dt_req),
        .dt_req_dly (dt_req_dly),
        .emu_dt     (emu_dt),
        .emu_time   (emu_time),
        .next_time  (next_time)
    );

    jitter_gen jitter_gen_i (
        .emu_clk     (emu_clk),
        .arst_n      (arst_n),
        .jitter_seed (jitter_seed),
        .jitter_mask (jitter_mask),
        .edge_seen   (edge_seen),
        .jitter      (jitter)
    );

    // pending output edges, oldest at the head
    edge_queue #(
        .queue_depth (queue_depth)
    ) edge_queue_i (
        .emu_clk   (emu_clk),
        .arst_n    (arst_n),
        .push      (push),
        .push_time (push_time),
        .pop       (pop),
        .head_time (head_time),
        .tail_time (tail_time),
        .empty     (empty),
        .full      (full)
    );

    edge_sched_fsm #(
        .delay_lsb (delay_lsb)
    ) edge_sched_fsm_i (
        .emu_clk    (emu_clk),
        .arst_n     (arst_n),
        .code       (code),
        .clk_i_val  (clk_i_val),
        .emu_time   (emu_time),
        .next_time  (next_time),
        .jitter     (jitter),
        .head_time  (head_time),
        .tail_time  (tail_time),
        .empty      (empty),
        .full       (full),
        .edge_seen  (edge_seen),
        .dt_req_dly (dt_req_dly),
        .push       (push),
        .push_time  (push_time),
        .pop        (pop),
        .clk_o_val  (clk_o_val),
        .overflow   (overflow)
    );

endmodule

// ==== bench/clk_delay_checker.sv ====
`timescale 1ns/1ps

module clk_delay_checker #(
    parameter int delay_lsb   = 4,
    parameter int queue_depth = 8
) (
    input  logic                                  emu_clk,
    input  logic                                  arst_n,
    input  logic [clk_delay_pkg::code_width-1:0]  code,
    input  logic                                  clk_i_val,
    input  logic [clk_delay_pkg::dt_width-1:0]    dt_req,
    input  logic [31:0]                           jitter_seed,
    input  logic [clk_delay_pkg::dt_width-1:0]    jitter_mask,
    input  logic                                  clk_o_val,
    input  logic [clk_delay_pkg::dt_width-1:0]    emu_dt,
    input  logic [clk_delay_pkg::time_width-1:0]  emu_time,
    input  logic                                  overflow,
    output int                                    check_count,
    output int                                    error_count,
    output int                                    bypass_count
);

    longint      m_time;
    logic        m_clk_o;
    logic        m_overflow;
    logic        m_in_q;
    logic        m_seeded;
    logic [15:0] m_lfsr;
    longint      deadlines [$];
    int          checks = 0;
    int          errors = 0;
    int          bypasses = 0;

    assign check_count  = checks;
    assign error_count  = errors;
    assign bypass_count = bypasses;

    // right-shifting galois step on the shared taps
    function automatic logic [15:0] jitter_lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ clk_delay_pkg::lfsr_poly) : (s >> 1);
    endfunction

    task automatic compare_value(input string name, input longint expected,
                                 input longint actual);
        checks = checks + 1;
        if (expected != actual) begin
            errors = errors + 1;
            $display("FAIL t=%0t %s expected %0d actual %0d", $time, name, expected, actual);
        end
    endtask

    // outputs are settled at the falling edge, inputs were driven after the rising one
    always @(negedge emu_clk) begin
        logic   edge_now;
        logic   was_full;
        longint cand;
        longint floor_t;
        longint near;
        logic   has_near;
        longint req;
        longint dt;
        longint next_t;
        if (!arst_n) begin
            m_time     = 0;
            m_clk_o    = 1'b0;
            m_overflow = 1'b0;
            m_in_q     = 1'b0;
            m_seeded   = 1'b0;
            deadlines.delete();
        end else begin
            if (!m_seeded) begin
                m_lfsr   = (jitter_seed[15:0] == 16'h0) ? 16'h1 : jitter_seed[15:0];
                m_seeded = 1'b1;
            end
            edge_now = (clk_i_val != m_in_q);
            // deadline with clamp to the present and to the newest queued edge
            cand    = m_time + longint'(code) * delay_lsb + longint'(m_lfsr & jitter_mask);
            floor_t = m_time + 1;
            if (deadlines.size() > 0 && deadlines[$] + 1 > floor_t) begin
                floor_t = deadlines[$] + 1;
            end
            if (cand < floor_t) begin
                cand = floor_t;
            end
            has_near = 1'b0;
            near     = 0;
            if (deadlines.size() > 0) begin
                near     = deadlines[0];
                has_near = 1'b1;
            end
            if (edge_now && (!has_near || cand < near)) begin
                near     = cand;
                has_near = 1'b1;
            end
            req = clk_delay_pkg::dt_max;
            if (has_near && near - m_time < req) begin
                req = near - m_time;
            end
            dt = (longint'(dt_req) < req) ? longint'(dt_req) : req;

            compare_value("emu_dt", dt, emu_dt);
            compare_value("emu_time", m_time, emu_time);
            compare_value("clk_o_val", m_clk_o, clk_o_val);
            compare_value("overflow", m_overflow, overflow);

            next_t   = m_time + dt;
            was_full = (deadlines.size() == queue_depth);
            if (deadlines.size() > 0 && next_t == deadlines[0]) begin
                void'(deadlines.pop_front());
                m_clk_o = ~m_clk_o;
            end else if (edge_now && next_t == cand) begin
                m_clk_o  = ~m_clk_o;
                bypasses = bypasses + 1;
            end
            if (edge_now && next_t != cand) begin
                if (was_full) begin
                    m_overflow = 1'b1;
                end else begin
                    deadlines.push_back(cand);
                end
            end
            if (edge_now) begin
                m_lfsr = jitter_lfsr_next(m_lfsr);
            end
            m_time = next_t;
            m_in_q = clk_i_val;
        end
    end

endmodule

// ==== bench/tb_clk_delay.sv ====
`timescale 1ns/1ps

module tb_clk_delay;

    localparam int delay_lsb   = 4;
    localparam int queue_depth = 8;
    localparam int row_count   = 7;
    localparam int cw          = clk_delay_pkg::code_width;
    localparam int dw          = clk_delay_pkg::dt_width;

    typedef struct {
        int cycles;
        int code;
        int half;
        int dt_req;
        int mask;
        int rand_gap;
    } row_t;

    // cycles, code, half period, dt_req, jitter_mask, random gap
    row_t rows [row_count] = '{
        '{20,  10, 30,  100, 0, 0},
        '{60,   8,  6,   16, 0, 0},
        '{80,  20,  8,    3, 0, 0},
        '{40,   1,  8,    3, 0, 0},
        '{60,   6,  5,   10, 7, 1},
        '{30,   1,  3, 1000, 0, 0},
        '{60, 200,  1,    2, 0, 0}
    };

    logic                                 emu_clk = 1'b0;
    logic                                 arst_n;
    logic [cw-1:0]                        code;
    logic                                 clk_i_val;
    logic [dw-1:0]                        dt_req;
    logic [31:0]                          jitter_seed;
    logic [dw-1:0]                        jitter_mask;
    logic                                 clk_o_val;
    logic [dw-1:0]                        emu_dt;
    logic [clk_delay_pkg::time_width-1:0] emu_time;
    logic                                 overflow;
    int                                   check_count;
    int                                   error_count;
    int                                   bypass_count;
    int                                   cycle_count = 0;
    int                                   timeout_limit = 50;
    logic [31:0]                          rand_state = 32'h85b;

    always #5 emu_clk = ~emu_clk;

    function automatic logic [31:0] gap_lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // one lfsr step per bit taken
    task automatic take_random_bits(input int nbits, output int value);
        value = 0;
        for (int i = 0; i < nbits; i++) begin
            value      = (value << 1) | int'(rand_state[0]);
            rand_state = gap_lfsr_next(rand_state);
        end
    endtask

    clk_delay_top #(
        .delay_lsb   (delay_lsb),
        .queue_depth (queue_depth)
    ) dut0 (
        .emu_clk     (emu_clk),
        .arst_n      (arst_n),
        .code        (code),
        .clk_i_val   (clk_i_val),
        .dt_req      (dt_req),
        .jitter_seed (jitter_seed),
        .jitter_mask (jitter_mask),
        .clk_o_val   (clk_o_val),
        .emu_dt      (emu_dt),
        .emu_time    (emu_time),
        .overflow    (overflow)
    );

    clk_delay_checker #(
        .delay_lsb   (delay_lsb),
        .queue_depth (queue_depth)
    ) chk0 (
        .emu_clk      (emu_clk),
        .arst_n       (arst_n),
        .code         (code),
        .clk_i_val    (clk_i_val),
        .dt_req       (dt_req),
        .jitter_seed  (jitter_seed),
        .jitter_mask  (jitter_mask),
        .clk_o_val    (clk_o_val),
        .emu_dt       (emu_dt),
        .emu_time     (emu_time),
        .overflow     (overflow),
        .check_count  (check_count),
        .error_count  (error_count),
        .bypass_count (bypass_count)
    );

    always @(posedge emu_clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > timeout_limit) begin
            $display("timeout: simulation ran past %0d cycles", timeout_limit);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    initial begin
        int phase;
        int target;
        int extra;
        int other_errors;
        other_errors = 0;
        arst_n       = 1'b0;
        code         = '0;
        clk_i_val    = 1'b0;
        dt_req       = dw'(rows[0].dt_req);
        jitter_seed  = 32'h0000_5a3c;
        jitter_mask  = '0;
        for (int r = 0; r < row_count; r++) begin
            timeout_limit = timeout_limit + rows[r].cycles;
        end
        repeat (2) @(posedge emu_clk);
        #1 arst_n = 1'b1;

        for (int r = 0; r < row_count; r++) begin
            code        = cw'(rows[r].code);
            dt_req      = dw'(rows[r].dt_req);
            jitter_mask = dw'(rows[r].mask);
            phase       = 0;
            target      = rows[r].half;
            for (int c = 0; c < rows[r].cycles; c++) begin
                @(posedge emu_clk);
                #1;
                phase = phase + 1;
                if (phase >= target) begin
                    clk_i_val = ~clk_i_val;
                    phase     = 0;
                    target    = rows[r].half;
                    if (rows[r].rand_gap != 0) begin
                        take_random_bits(2, extra);
                        target = target + extra;
                    end
                end
            end
        end

        @(negedge emu_clk);
        #1;
        // the last row must have filled the queue, and short delays must have bypassed it
        if (!overflow) begin
            $display("the queue never overflowed during the fast input row");
            other_errors = other_errors + 1;
        end
        if (bypass_count == 0) begin
            $display("no output edge took the bypass path");
            other_errors = other_errors + 1;
        end
        $display("checks: %0d, value errors: %0d, other errors: %0d",
                 check_count, error_count, other_errors);
        if (error_count == 0 && other_errors == 0 && check_count > 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== filelist.f ====
source/clk_delay_pkg.sv
source/timestep_ctrl.sv
source/jitter_gen.sv
source/edge_queue.sv
source/edge_sched_fsm.sv
source/clk_delay_top.sv
bench/clk_delay_checker.sv
bench/tb_clk_delay.sv

// ==== Makefile ====
TOP = tb_clk_delay

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -sv -f filelist.f --top-module $(TOP) -Mdir obj_dir

run: build
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "TEST RESULT: PASS" sim.log

lint:
	verilator --lint-only -Wall --timing -sv -f filelist.f --top-module clk_delay_top
	verilator --lint-only --timing -sv -f filelist.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log
